/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_core
RTL_TOP    ?= core_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS := $(shell grep -v '^+' $(FILELIST)) include/tb_types.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/core_top.sv
testbench/core_checker.sv
testbench/tb_core.sv

/* rtl/core_pkg.sv */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] word_t;

    // major opcodes, RV32I encodings
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg,    // value read in decode
        fwd_mem,    // instruction now in memory stage
        fwd_wb      // instruction now retiring
    } fwd_sel_e;

    typedef struct packed {
        logic                  valid;
        word_t                 pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic                  mem_re;
        logic                  mem_we;
        logic                  is_branch;
        logic                  branch_ne;  // bne when set, beq otherwise
        logic                  is_jal;
        logic                  is_halt;
        logic                  use_imm;    // operand b from imm
        alu_op_e               alu_op;
        word_t                 imm;
        word_t                 rs1_val;
        word_t                 rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        word_t                 pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic                  mem_re;
        logic                  mem_we;
        logic                  is_halt;
        word_t                 result;     // alu result or load/store address
        word_t                 store_val;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        word_t                 pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        word_t                 data;
    } retire_t;

endpackage

/* rtl/core_top.sv */
`timescale 1ns/100ps

module core_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          load_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr_i,
    input  core_pkg::word_t               load_data_i,
    output core_pkg::retire_t             retire_o,
    output logic                          halt_o
);
    import core_pkg::*;

    logic                  if_valid;
    word_t                 if_pc;
    word_t                 if_instr;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    word_t                 rs1_val;
    word_t                 rs2_val;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic                  stall;
    logic                  flush;
    logic                  taken;
    word_t                 target;
    word_t                 mem_fwd;

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .stall_i     (stall),
        .redirect_i  (taken),
        .target_i    (target),
        .halt_i      (halt_o),
        .valid_o     (if_valid),
        .pc_o        (if_pc),
        .instr_o     (if_instr)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (if_valid),
        .pc_i      (if_pc),
        .instr_i   (if_instr),
        .stall_i   (stall),
        .flush_i   (flush),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .id_ex_o   (id_ex)
    );

    reg_file u_regs (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs1_i     (dec_rs1),
        .rs2_i     (dec_rs2),
        .we_i      (retire_o.reg_we),
        .rd_i      (retire_o.rd),
        .wdata_i   (retire_o.data),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    hazard_unit u_hazard (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .dec_rs1_i (dec_rs1),
        .dec_rs2_i (dec_rs2),
        .id_ex_i   (id_ex),
        .ex_mem_i  (ex_mem),
        .wb_rd_i   (retire_o.rd),
        .wb_we_i   (retire_o.reg_we),
        .taken_i   (taken),
        .stall_o   (stall),
        .flush_o   (flush),
        .fwd_a_o   (fwd_a),
        .fwd_b_o   (fwd_b)
    );

    exec_stage u_exec (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .id_ex_i   (id_ex),
        .fwd_a_i   (fwd_a),
        .fwd_b_i   (fwd_b),
        .mem_fwd_i (mem_fwd),
        .wb_fwd_i  (retire_o.data),
        .taken_o   (taken),
        .target_o  (target),
        .ex_mem_o  (ex_mem)
    );

    mem_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ex_mem_i  (ex_mem),
        .mem_fwd_o (mem_fwd),
        .retire_o  (retire_o),
        .halt_o    (halt_o)
    );

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            valid_i,
    input  core_pkg::word_t                 pc_i,
    input  core_pkg::word_t                 instr_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  core_pkg::word_t                 rs1_val_i,
    input  core_pkg::word_t                 rs2_val_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output core_pkg::id_ex_t                id_ex_o
);
    import core_pkg::*;

    opcode_e opcode;
    logic    use_rs1;
    logic    use_rs2;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    id_ex_t  dec;

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b  = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
    assign imm_j  = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        dec.pc     = pc_i;
        dec.rd     = instr_i[11:7];
        dec.alu_op = alu_add;
        case (opcode)
            op_reg: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.reg_we = 1'b1;
                dec.alu_op = alu_decode(instr_i[14:12], instr_i[30]);
            end
            op_imm: begin
                use_rs1     = 1'b1;
                dec.reg_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.alu_op  = alu_decode(instr_i[14:12], 1'b0);  // no subi
            end
            op_load: begin
                use_rs1     = 1'b1;
                dec.reg_we  = 1'b1;
                dec.mem_re  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            op_store: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.mem_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
            end
            op_branch: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = instr_i[12];  // funct3 001 is bne
                dec.imm       = imm_b;
            end
            op_jal: begin
                dec.reg_we = 1'b1;
                dec.is_jal = 1'b1;
                dec.imm    = imm_j;
            end
            op_system: dec.is_halt = 1'b1;  // only ebreak is supported
            default: ;
        endcase
        dec.valid = valid_i;
        dec.rs1   = use_rs1 ? instr_i[19:15] : '0;  // unused sources read as x0
        dec.rs2   = use_rs2 ? instr_i[24:20] : '0;
        if (!valid_i) begin
            dec = '0;
        end
    end

    assign rs1_o = dec.rs1;
    assign rs2_o = dec.rs2;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (stall_i || flush_i) begin
            id_ex_o <= '0;                // bubble
        end else begin
            id_ex_o         <= dec;
            id_ex_o.rs1_val <= rs1_val_i;
            id_ex_o.rs2_val <= rs2_val_i;
        end
    end

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  core_pkg::id_ex_t   id_ex_i,
    input  core_pkg::fwd_sel_e fwd_a_i,
    input  core_pkg::fwd_sel_e fwd_b_i,
    input  core_pkg::word_t    mem_fwd_i,
    input  core_pkg::word_t    wb_fwd_i,
    output logic               taken_o,
    output core_pkg::word_t    target_o,
    output core_pkg::ex_mem_t  ex_mem_o
);
    import core_pkg::*;

    word_t src_a;
    word_t rs2_fwd;
    word_t src_b;
    word_t alu_res;
    logic  equal;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a   = fwd_mux(fwd_a_i, id_ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
    assign rs2_fwd = fwd_mux(fwd_b_i, id_ex_i.rs2_val, mem_fwd_i, wb_fwd_i);
    assign src_b   = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.alu_op)
            alu_sub: alu_res = src_a - src_b;
            alu_and: alu_res = src_a & src_b;
            alu_or:  alu_res = src_a | src_b;
            alu_xor: alu_res = src_a ^ src_b;
            alu_slt: alu_res = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default: alu_res = src_a + src_b;
        endcase
    end

    // beq and bne compare the two register sources
    assign equal    = (src_a == rs2_fwd);
    assign taken_o  = id_ex_i.valid && (id_ex_i.is_jal ||
                      (id_ex_i.is_branch && (equal != id_ex_i.branch_ne)));
    assign target_o = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.valid     <= id_ex_i.valid;
            ex_mem_o.pc        <= id_ex_i.pc;
            ex_mem_o.rd        <= id_ex_i.rd;
            ex_mem_o.reg_we    <= id_ex_i.reg_we;
            ex_mem_o.mem_re    <= id_ex_i.mem_re;
            ex_mem_o.mem_we    <= id_ex_i.mem_we;
            ex_mem_o.is_halt   <= id_ex_i.is_halt;
            ex_mem_o.result    <= id_ex_i.is_jal ? id_ex_i.pc + XLEN'(4) : alu_res;  // link
            ex_mem_o.store_val <= rs2_fwd;
        end
    end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          load_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr_i,
    input  core_pkg::word_t               load_data_i,
    input  logic                          stall_i,
    input  logic                          redirect_i,
    input  core_pkg::word_t               target_i,
    input  logic                          halt_i,
    output logic                          valid_o,
    output core_pkg::word_t               pc_o,
    output core_pkg::word_t               instr_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    word_t             imem [IMEM_DEPTH];
    word_t             pc_q;
    logic [IDX_W-1:0]  fetch_idx;

    assign fetch_idx = pc_q[IDX_W+1:2];  // word index, wraps at depth

    // program load, only while the core sits in reset
    always_ff @(posedge clk) begin
        if (!arst_n_i && load_we_i) begin
            imem[load_addr_i] <= load_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= '0;
            valid_o <= 1'b0;
        end else if (halt_i) begin
            valid_o <= 1'b0;         // frozen after ebreak
        end else if (redirect_i) begin
            pc_q    <= target_i;
            valid_o <= 1'b0;         // wrong-path slot
        end else if (!stall_i) begin
            pc_q    <= pc_q + XLEN'(4);
            valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_o    <= pc_q;
            instr_o <= imem[fetch_idx];
        end
    end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs2_i,
    input  core_pkg::id_ex_t                id_ex_i,
    input  core_pkg::ex_mem_t               ex_mem_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                            wb_we_i,
    input  logic                            taken_i,
    output logic                            stall_o,
    output logic                            flush_o,
    output core_pkg::fwd_sel_e              fwd_a_o,
    output core_pkg::fwd_sel_e              fwd_b_o
);
    import core_pkg::*;

    function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] rs, input ex_mem_t ex_mem,
                                      input logic [REG_ADDR_W-1:0] wb_rd, input logic wb_we);
        fwd_sel_e sel;
        sel = fwd_reg;
        if (rs != '0 && wb_we && wb_rd == rs) begin
            sel = fwd_wb;
        end
        if (rs != '0 && ex_mem.valid && ex_mem.reg_we && ex_mem.rd == rs) begin
            sel = fwd_mem;  // younger producer wins
        end
        return sel;
    endfunction

    assign fwd_a_o = pick(id_ex_i.rs1, ex_mem_i, wb_rd_i, wb_we_i);
    assign fwd_b_o = pick(id_ex_i.rs2, ex_mem_i, wb_rd_i, wb_we_i);

    // load in execute feeding the instruction in decode
    assign stall_o = id_ex_i.valid && id_ex_i.mem_re && id_ex_i.reg_we && id_ex_i.rd != '0
                     && (id_ex_i.rd == dec_rs1_i || id_ex_i.rd == dec_rs2_i);
    assign flush_o = taken_i;

    a_no_stall_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(stall_o && flush_o));

    // the bubble behind a stall means a load-use stall never lasts two cycles
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_o |=> !stall_o);

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  core_pkg::ex_mem_t ex_mem_i,
    output core_pkg::word_t   mem_fwd_o,
    output core_pkg::retire_t retire_o,
    output logic              halt_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    word_t            dmem [DMEM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic             live;
    word_t            load_val;

    assign idx      = ex_mem_i.result[IDX_W+1:2];  // word aligned, wraps at depth
    assign live     = ex_mem_i.valid && !halt_o;   // nothing commits after ebreak
    assign load_val = dmem[idx];

    always_ff @(posedge clk) begin
        if (live && ex_mem_i.mem_we) begin
            dmem[idx] <= ex_mem_i.store_val;
        end
    end

    // value seen by execute through the fwd_mem path
    assign mem_fwd_o = ex_mem_i.mem_re ? load_val : ex_mem_i.result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_o <= '0;
            halt_o   <= 1'b0;
        end else begin
            retire_o.valid  <= live;
            retire_o.pc     <= ex_mem_i.pc;
            retire_o.rd     <= ex_mem_i.rd;
            retire_o.reg_we <= live && ex_mem_i.reg_we;
            retire_o.data   <= mem_fwd_o;
            if (live && ex_mem_i.is_halt) begin
                halt_o <= 1'b1;  // sticky
            end
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
    input  core_pkg::word_t                 wdata_i,
    output core_pkg::word_t                 rs1_val_o,
    output core_pkg::word_t                 rs2_val_o
);
    import core_pkg::*;

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // write-through covers the writeback to decode distance
    assign rs1_val_o = (we_i && rd_i != '0 && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
    assign rs2_val_o = (we_i && rd_i != '0 && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

    // x0 relies on its reset value and on both write paths skipping it
    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rs1_i != '0 || rs1_val_o == '0) && (rs2_i != '0 || rs2_val_o == '0));

endmodule

/* include/tb_types.svh */
`ifndef TB_TYPES_SVH
`define TB_TYPES_SVH

// expected outcome of one test program
typedef struct packed {
    logic [8*12-1:0]  name;
    logic [2:0]       n_chk;      // used entries of rd and val
    logic [5:0][4:0]  rd;
    logic [5:0][31:0] val;
    logic [15:0]      forbid;     // word indices on the wrong path
    logic [7:0]       retires;
    logic [31:0]      ebreak_pc;
} test_exp_t;

`endif

/* testbench/core_checker.sv */
`timescale 1ns/100ps
`include "tb_types.svh"

module core_checker (
    input  logic              clk,
    input  logic              arst_n_i,
    input  core_pkg::retire_t retire_i,
    input  logic              halt_i,
    input  test_exp_t         exp_i,
    output logic              done_o,
    output int                pass_cnt_o,
    output int                fail_cnt_o
);
    import core_pkg::*;

    word_t       shadow [32];  // registers rebuilt from retire records
    logic [15:0] seen;
    int          retire_cnt;
    int          errs;
    logic        halted;
    logic        first;

    initial begin
        done_o     = 1'b0;
        pass_cnt_o = 0;
        fail_cnt_o = 0;
    end

    task automatic note_retire();
        if (retire_i.pc[31:6] != '0 || exp_i.forbid[retire_i.pc[5:2]]) begin
            $display("ERROR: test %0s retired wrong-path instruction at pc %h",
                     exp_i.name, retire_i.pc);
            errs++;
        end else if (seen[retire_i.pc[5:2]]) begin
            $display("ERROR: test %0s retired instruction at pc %h twice",
                     exp_i.name, retire_i.pc);
            errs++;
        end
        seen[retire_i.pc[5:2]] = 1'b1;
        retire_cnt++;
        if (retire_i.reg_we && retire_i.rd != '0) begin
            shadow[retire_i.rd] = retire_i.data;
        end
    endtask

    task automatic compare_regs();
        for (int i = 0; i < int'(exp_i.n_chk); i++) begin
            if (shadow[exp_i.rd[i]] !== exp_i.val[i]) begin
                $display("MISMATCH test %0s x%0d expected %h actual %h", exp_i.name,
                         exp_i.rd[i], exp_i.val[i], shadow[exp_i.rd[i]]);
                errs++;
            end
        end
    endtask

    task automatic finish_test();
        halted = 1'b1;
        if (!(retire_i.valid && retire_i.pc == exp_i.ebreak_pc)) begin
            $display("ERROR: test %0s raised halt without the ebreak at pc %h retiring",
                     exp_i.name, exp_i.ebreak_pc);
            errs++;
        end
        compare_regs();
        if (retire_cnt != int'(exp_i.retires)) begin
            $display("MISMATCH test %0s retire count expected %0d actual %0d",
                     exp_i.name, exp_i.retires, retire_cnt);
            errs++;
        end
        if (errs == 0) begin
            $display("test %0s passed", exp_i.name);
            pass_cnt_o++;
        end else begin
            $display("test %0s failed with %0d errors", exp_i.name, errs);
            fail_cnt_o++;
        end
        done_o = 1'b1;
    endtask

    // samples the values that settled during the previous cycle
    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            seen       = '0;
            retire_cnt = 0;
            errs       = 0;
            halted     = 1'b0;
            first      = 1'b1;
            done_o     = 1'b0;
        end else begin
            if (first && (retire_i.valid || halt_i)) begin
                $display("ERROR: test %0s saw retire or halt high right after reset",
                         exp_i.name);
                errs++;
            end
            first = 1'b0;
            if (halted && retire_i.valid) begin
                $display("ERROR: test %0s retired pc %h after halt", exp_i.name, retire_i.pc);
                errs++;
            end
            if (retire_i.valid && !halted) begin
                note_retire();
            end
            if (halt_i && !halted) begin
                finish_test();
            end
        end
    end

endmodule

/* testbench/tb_core.sv */
`timescale 1ns/100ps
`include "tb_types.svh"

module tb_core;
    import core_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int PROG_WORDS = 16;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    logic      clk;
    logic      arst_n_i;
    logic      load_we;
    logic [7:0] load_addr;
    word_t     load_data;
    retire_t   retire;
    logic      halt;
    test_exp_t cur_exp;
    logic      done;
    int        pass_cnt;
    int        fail_cnt;

    test_exp_t test_tbl [NUM_TESTS];
    word_t     prog [NUM_TESTS][PROG_WORDS];
    int        prog_len [NUM_TESTS];
    int        cur_test    = 0;
    int        cycles      = 0;
    int        cycle_limit = 0;

    core_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .retire_o    (retire),
        .halt_o      (halt)
    );

    core_checker chk (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .retire_i   (retire),
        .halt_i     (halt),
        .exp_i      (cur_exp),
        .done_o     (done),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    // RV32I encoders, operands in assembly order
    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                    input int off);
        logic [12:0] i;
        i = 13'(off);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(input int rd, input int off);
        logic [20:0] i;
        i = 21'(off);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return enc_i(7'b0010011, 3'b000, rd, rs1, imm);
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return enc_i(7'b0000011, 3'b010, rd, rs1, imm);
    endfunction

    // unused imem words, addi x0 with the word index as immediate
    function automatic word_t fill_word(input int idx);
        return {12'(idx), 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    task automatic put(input int t, input word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic want(input int t, input int rd, input word_t val);
        test_tbl[t].rd[test_tbl[t].n_chk]  = 5'(rd);
        test_tbl[t].val[test_tbl[t].n_chk] = val;
        test_tbl[t].n_chk                  = test_tbl[t].n_chk + 3'd1;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_tbl[t] = '0;
            prog_len[t] = 0;
        end
        test_tbl[0].name = "alu_ops";
        put(0, addi(1, 0, 7));
        put(0, addi(2, 0, -3));
        put(0, enc_r(7'h00, 3'b000, 3, 1, 2));  // add
        put(0, enc_r(7'h20, 3'b000, 4, 1, 2));  // sub
        put(0, enc_r(7'h00, 3'b111, 5, 1, 2));  // and
        put(0, enc_r(7'h00, 3'b110, 6, 1, 2));  // or
        put(0, enc_r(7'h00, 3'b100, 7, 1, 2));  // xor
        put(0, enc_r(7'h00, 3'b010, 8, 2, 1));  // slt, -3 < 7
        want(0, 3, 32'd4);
        want(0, 4, 32'd10);
        want(0, 5, 32'd5);
        want(0, 6, 32'hffffffff);
        want(0, 7, 32'hfffffffa);
        want(0, 8, 32'd1);
        test_tbl[1].name = "forwarding";
        put(1, addi(1, 0, 5));
        put(1, addi(2, 1, 3));                   // x1 one slot back
        put(1, enc_r(7'h00, 3'b000, 3, 2, 1));   // x2 and x1 from two stages
        put(1, enc_r(7'h00, 3'b000, 4, 3, 2));
        put(1, enc_r(7'h00, 3'b000, 5, 4, 1));   // x1 from the register file
        put(1, enc_r(7'h20, 3'b000, 6, 5, 3));
        want(1, 2, 32'd8);
        want(1, 3, 32'd13);
        want(1, 4, 32'd21);
        want(1, 5, 32'd26);
        want(1, 6, 32'd13);
        test_tbl[2].name = "load_use";
        put(2, addi(1, 0, 'h40));
        put(2, addi(2, 0, 123));
        put(2, enc_sw(2, 1, 0));
        put(2, lw(3, 1, 0));
        put(2, enc_r(7'h00, 3'b000, 4, 3, 3));  // needs the load right away
        put(2, enc_r(7'h00, 3'b000, 5, 4, 3));
        want(2, 3, 32'd123);
        want(2, 4, 32'd246);
        want(2, 5, 32'd369);
        test_tbl[3].name = "branches";
        put(3, addi(1, 0, 1));
        put(3, addi(2, 0, 1));
        put(3, enc_b(3'b000, 1, 2, 12));        // beq taken to 20
        put(3, addi(10, 0, 99));
        put(3, addi(10, 0, 98));
        put(3, enc_b(3'b001, 1, 2, 8));         // bne not taken
        put(3, addi(3, 0, 3));
        put(3, enc_b(3'b001, 1, 0, 12));        // bne taken to 40
        put(3, addi(11, 0, 99));
        put(3, addi(11, 0, 98));
        put(3, enc_b(3'b000, 1, 0, 8));         // beq not taken
        put(3, addi(4, 0, 4));
        test_tbl[3].forbid = 16'b0000_0011_0001_1000;
        want(3, 3, 32'd3);
        want(3, 4, 32'd4);
        want(3, 10, 32'd0);
        want(3, 11, 32'd0);
        test_tbl[4].name = "jal_link";
        put(4, addi(1, 0, 1));
        put(4, enc_jal(5, 12));                 // to 16, link 8
        put(4, addi(6, 0, 99));
        put(4, addi(6, 0, 98));
        put(4, enc_r(7'h00, 3'b000, 7, 5, 1));
        test_tbl[4].forbid = 16'b0000_0000_0000_1100;
        want(4, 5, 32'd8);
        want(4, 6, 32'd0);
        want(4, 7, 32'd9);
        test_tbl[5].name = "store_load";
        put(5, addi(1, 0, 'h80));
        put(5, addi(2, 0, 'h5a5));
        put(5, enc_sw(2, 1, 4));
        put(5, addi(3, 0, -1));
        put(5, enc_sw(3, 1, 8));
        put(5, lw(4, 1, 4));
        put(5, lw(5, 1, 8));
        put(5, enc_r(7'h00, 3'b100, 6, 4, 5));
        want(5, 4, 32'h000005a5);
        want(5, 5, 32'hffffffff);
        want(5, 6, 32'hfffffa5a);
        for (int t = 0; t < NUM_TESTS; t++) begin
            put(t, 32'h00100073);               // ebreak
            test_tbl[t].ebreak_pc = 32'(4 * (prog_len[t] - 1));
            test_tbl[t].retires   = 8'(prog_len[t] - $countones(test_tbl[t].forbid));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit from the summed program lengths
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("ERROR: timeout, test %0s never halted", test_tbl[cur_test].name);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        arst_n_i  = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        cur_exp   = '0;
        build_table();
        cycle_limit = 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycle_limit += 20 * prog_len[t];
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = t;
            @(posedge clk);
            arst_n_i <= 1'b0;
            cur_exp  <= test_tbl[t];
            // program goes in while the core sits in reset
            for (int i = 0; i < PROG_WORDS; i++) begin
                @(posedge clk);
                load_we   <= 1'b1;
                load_addr <= 8'(i);
                load_data <= (i < prog_len[t]) ? prog[t][i] : fill_word(i);
            end
            @(posedge clk);
            load_we  <= 1'b0;
            arst_n_i <= 1'b1;
            wait (done);
        end
        $display("summary: %0d tests, %0d passed, %0d failed", NUM_TESTS, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
